//--- l2_miss_unit_cfg.svh
// Build time constants of the L2 miss unit.
// The FIFO depth follows the tracker depth so the queue can never overflow
// while the tracker still has a free slot.
`ifndef L2_MISS_UNIT_CFG_SVH
`define L2_MISS_UNIT_CFG_SVH

// bits in a cache line address as seen by the miss logic
`define L2_LINE_ADDR_BITS 26

// tracker slots, and also the number of miss FIFO slots
// keep this a power of two
`define L2_PENDING_ENTRIES 16

// cycles that memory gets to answer each phase of the req/ack handshake
`define L2_ACK_TIMEOUT 64

`endif

//--- l2_miss_unit_pkg.sv
// Shared types for the L2 miss tracking front end.
// Widths come from the cfg header, so the header must be visible when this
// package is compiled.
`include "l2_miss_unit_cfg.svh"

package l2_miss_unit_pkg;

	// a cache line address with the offset bits already stripped off
	typedef logic [`L2_LINE_ADDR_BITS - 1:0] l2_line_addr_t;

	// selects one slot of the pending miss tracker
	typedef logic [$clog2(`L2_PENDING_ENTRIES) - 1:0] pm_index_t;

	// memory handshake sequencer states
	// DONE_LOW is the one cycle abort state entered after a handshake timeout
	typedef enum logic [1:0]
	{
		IDLE,
		REQ_HIGH,
		WAIT_ACK_LOW,
		DONE_LOW
	} mem_fsm_state_t;

endpackage

//--- cam.sv
// Small fully associative lookup table built from flops.
// Lookup is combinational, update lands at the next rising edge.
// The index ports use pm_index_t, so NUM_ENTRIES must fit in that type.
// Callers must never write a key that is already held by another valid entry.
`timescale 1ns/100ps

module cam
	import l2_miss_unit_pkg::*;
	#(parameter int NUM_ENTRIES = 16,
	parameter int KEY_WIDTH = 26)
	(input clk,
	input reset,
	input [KEY_WIDTH - 1:0] lookup_key,
	output logic lookup_hit,
	output pm_index_t lookup_index,
	input update_en,
	input pm_index_t update_index,
	input [KEY_WIDTH - 1:0] update_key,
	input update_valid);

	logic [KEY_WIDTH - 1:0] keys [NUM_ENTRIES];
	logic [NUM_ENTRIES - 1:0] entry_valid;
	logic [NUM_ENTRIES - 1:0] match;

	// every valid entry is compared against the key in parallel
	always_comb
	begin
		for (int i = 0; i < NUM_ENTRIES; i++)
			match[i] = entry_valid[i] && keys[i] == lookup_key;
	end

	// at most one entry can match, so the last hit found is the only one
	always_comb
	begin
		lookup_hit = 1'b0;
		lookup_index = '0;
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			if (match[i])
			begin
				lookup_hit = 1'b1;
				lookup_index = pm_index_t'(i);
			end
		end
	end

	// update_valid low invalidates the selected entry
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			entry_valid <= '0;
		else if (update_en)
			entry_valid[update_index] <= update_valid;
	end

	always_ff @(posedge clk)
	begin
		if (update_en && update_valid)
			keys[update_index] <= update_key;
	end

	// the owner of the table must keep keys unique across all valid slots
	unique_keys: assert property (@(posedge clk) disable iff (reset) $onehot0(match))
		else $error("cam: more than one valid entry matches the lookup key");

endmodule

//--- pending_miss_tracker.sv
// Remembers every line that has a miss in flight to memory.
// The request stage must hold off new misses while pending_full is high.
// A fill is expected only for a line that is currently pending.
// duplicate_request is combinational in the request cycle.
`timescale 1ns/100ps
`include "l2_miss_unit_cfg.svh"

module pending_miss_tracker
	import l2_miss_unit_pkg::*;
	(input clk,
	input reset,
	input req_valid,
	input l2_line_addr_t req_address,
	input req_is_miss,
	input req_is_fill,
	output logic duplicate_request,
	output logic pending_full,
	output logic push,
	output l2_line_addr_t push_address);

	logic cam_hit;
	pm_index_t hit_index;
	pm_index_t next_free;
	// a set bit marks a slot that holds no pending line
	logic [`L2_PENDING_ENTRIES - 1:0] free_entries;
	logic [`L2_PENDING_ENTRIES - 1:0] next_free_oh;
	logic record;
	logic clear;

	// isolate the lowest free slot
	assign next_free_oh = free_entries & ~(free_entries - 1'b1);

	// one hot to binary index
	always_comb
	begin
		next_free = '0;
		for (int i = 0; i < `L2_PENDING_ENTRIES; i++)
		begin
			if (next_free_oh[i])
				next_free = pm_index_t'(i);
		end
	end

	// a new miss takes a free slot, a fill frees the slot it hits
	assign record = req_valid && req_is_miss && !cam_hit;
	assign clear = req_valid && req_is_fill && cam_hit;

	assign duplicate_request = req_valid && cam_hit;
	assign pending_full = free_entries == '0;

	// only first misses to a line go on toward memory
	assign push = record;
	assign push_address = req_address;

	cam #(.NUM_ENTRIES(`L2_PENDING_ENTRIES), .KEY_WIDTH(`L2_LINE_ADDR_BITS)) lookup_cam(
		.clk(clk),
		.reset(reset),
		.lookup_key(req_address),
		.lookup_hit(cam_hit),
		.lookup_index(hit_index),
		.update_en(record || clear),
		.update_index(cam_hit ? hit_index : next_free),
		.update_key(req_address),
		.update_valid(record));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			free_entries <= '1;
		else if (record)
			free_entries[next_free] <= 1'b0;
		else if (clear)
			free_entries[hit_index] <= 1'b1;
	end

	// a miss while full would overwrite slot zero
	no_miss_when_full: assert property (@(posedge clk) disable iff (reset)
		req_valid && req_is_miss |-> !pending_full)
		else $error("tracker: miss presented while pending_full is high");

	fill_hits_pending: assert property (@(posedge clk) disable iff (reset)
		req_valid && req_is_fill |-> cam_hit)
		else $error("tracker: fill for a line with no pending miss");

endmodule

//--- miss_fifo.sv
// Circular queue of line addresses waiting to go to memory.
// There is no full output, because the tracker bounds the number of pushes.
// The head entry is readable on pop_address while fifo_empty is low.
// DEPTH must be at least 2.
`timescale 1ns/100ps
`include "l2_miss_unit_cfg.svh"

module miss_fifo
	import l2_miss_unit_pkg::*;
	#(parameter int DEPTH = `L2_PENDING_ENTRIES)
	(input clk,
	input reset,
	input push,
	input l2_line_addr_t push_address,
	input pop,
	output l2_line_addr_t pop_address,
	output logic fifo_empty);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	l2_line_addr_t storage [DEPTH];
	logic [PTR_W - 1:0] wr_ptr;
	logic [PTR_W - 1:0] rd_ptr;
	logic [CNT_W - 1:0] count;
	logic fifo_full;

	assign fifo_empty = count == '0;
	assign fifo_full = count == CNT_W'(DEPTH);
	assign pop_address = storage[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			storage[wr_ptr] <= push_address;
	end

	// pointers wrap explicitly so depths that are not a power of two work too
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr == PTR_W'(DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr == PTR_W'(DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// the tracker depth is what keeps this from ever firing
	no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !fifo_full)
		else $error("miss_fifo: push while full");

	no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> !fifo_empty)
		else $error("miss_fifo: pop while empty");

endmodule

//--- mem_req_fsm.sv
// Drains the miss FIFO to memory, one four phase req/ack handshake at a time.
// mem_address is held from the pop until the handshake is over.
// A phase timeout aborts the transaction, drops the entry and sets mem_error,
// which stays high until reset.
`timescale 1ns/100ps

module mem_req_fsm
	import l2_miss_unit_pkg::*;
	(input clk,
	input reset,
	input fifo_empty,
	output logic pop,
	input l2_line_addr_t pop_address,
	output logic mem_req,
	output l2_line_addr_t mem_address,
	input mem_ack,
	input timeout,
	output logic timer_run,
	output logic timer_clear,
	output logic mem_error);

	mem_fsm_state_t state;
	mem_fsm_state_t state_next;

	always_comb
	begin
		state_next = state;
		unique case (state)
			IDLE:
				if (!fifo_empty)
					state_next = REQ_HIGH;
			// waiting for memory to raise ack
			REQ_HIGH:
				if (timeout)
					state_next = DONE_LOW;
				else if (mem_ack)
					state_next = WAIT_ACK_LOW;
			// req is down, waiting for memory to drop ack
			WAIT_ACK_LOW:
				if (timeout)
					state_next = DONE_LOW;
				else if (!mem_ack)
					state_next = IDLE;
			DONE_LOW:
				state_next = IDLE;
			default:
				state_next = IDLE;
		endcase
	end

	// the head is taken on the same edge that raises mem_req
	assign pop = state == IDLE && !fifo_empty;
	assign mem_req = state == REQ_HIGH;
	assign timer_run = state == REQ_HIGH || state == WAIT_ACK_LOW;
	// restart the phase timer on every state change
	assign timer_clear = state_next != state;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			mem_error <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (state_next == DONE_LOW)
				mem_error <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
			mem_address <= pop_address;
	end

	addr_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req && $past(mem_req) |-> mem_address == $past(mem_address))
		else $error("mem_req_fsm: mem_address changed while mem_req was high");

endmodule

//--- ack_timer.sv
// Watchdog for one phase of the memory handshake.
// Counts while timer_run is high and saturates at the timeout value.
// timer_clear wins over counting and zeroes the count.
`timescale 1ns/100ps
`include "l2_miss_unit_cfg.svh"

module ack_timer
	(input clk,
	input reset,
	input timer_run,
	input timer_clear,
	output logic timeout);

	localparam int CNT_W = $clog2(`L2_ACK_TIMEOUT + 1);

	logic [CNT_W - 1:0] count;

	assign timeout = count == CNT_W'(`L2_ACK_TIMEOUT);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (timer_clear)
			count <= '0;
		else if (timer_run && !timeout)
			count <= count + 1'b1;
	end

	// the sequencer must leave its waiting state in the very cycle it sees timeout
	timeout_ends_phase: assert property (@(posedge clk) disable iff (reset)
		timeout |-> timer_run && timer_clear)
		else $error("ack_timer: timeout was not acted on by the sequencer");

endmodule

//--- l2_miss_unit.sv
// Miss tracking front of the L2 cache.
// One request per cycle; req_is_miss and req_is_fill are never both high.
// No misses may be presented while pending_full is high.
// mem_error is sticky and clears only on reset.
`timescale 1ns/100ps
`include "l2_miss_unit_cfg.svh"

module l2_miss_unit
	import l2_miss_unit_pkg::*;
	(input clk,
	input reset,
	input req_valid,
	input l2_line_addr_t req_address,
	input req_is_miss,
	input req_is_fill,
	output logic duplicate_request,
	output logic pending_full,
	output logic mem_req,
	output l2_line_addr_t mem_address,
	input mem_ack,
	output logic mem_error);

	logic push;
	l2_line_addr_t push_address;
	logic pop;
	l2_line_addr_t pop_address;
	logic fifo_empty;
	logic timer_run;
	logic timer_clear;
	logic timeout;

	pending_miss_tracker tracker_inst(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_address(req_address),
		.req_is_miss(req_is_miss),
		.req_is_fill(req_is_fill),
		.duplicate_request(duplicate_request),
		.pending_full(pending_full),
		.push(push),
		.push_address(push_address));

	// same depth as the tracker so it can never overflow
	miss_fifo #(.DEPTH(`L2_PENDING_ENTRIES)) fifo_inst(
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_address(push_address),
		.pop(pop),
		.pop_address(pop_address),
		.fifo_empty(fifo_empty));

	mem_req_fsm fsm_inst(
		.clk(clk),
		.reset(reset),
		.fifo_empty(fifo_empty),
		.pop(pop),
		.pop_address(pop_address),
		.mem_req(mem_req),
		.mem_address(mem_address),
		.mem_ack(mem_ack),
		.timeout(timeout),
		.timer_run(timer_run),
		.timer_clear(timer_clear),
		.mem_error(mem_error));

	ack_timer timer_inst(
		.clk(clk),
		.reset(reset),
		.timer_run(timer_run),
		.timer_clear(timer_clear),
		.timeout(timeout));

endmodule

//--- l2_miss_unit_tb.sv
// Testbench for the L2 miss unit, acting as request pipeline and as memory.
// Requests, expected flags and the expected memory order come from
// l2_miss_unit_vectors.txt, opened relative to the directory the run starts in.
// Memory delays come from an LFSR with a fixed seed, so every run is the same.
// A test that sets mute leaves memory silent for the rest of the run.
`timescale 1ns/100ps
`include "l2_miss_unit_cfg.svh"

module l2_miss_unit_tb
	import l2_miss_unit_pkg::*;
	();

	localparam int QUIET_CYCLES = 10;
	localparam int DRAIN_LIMIT = 3000;
	localparam int PHASE_LIMIT = 20;

	logic clk;
	logic reset;
	logic req_valid;
	l2_line_addr_t req_address;
	logic req_is_miss;
	logic req_is_fill;
	logic duplicate_request;
	logic pending_full;
	logic mem_req;
	l2_line_addr_t mem_address;
	logic mem_ack;
	logic mem_error;

	// one entry per vectors line
	int vec_test[$];
	string vec_kind[$];
	l2_line_addr_t vec_addr[$];
	logic vec_dup[$];

	// every address seen at a rising mem_req, in order
	l2_line_addr_t mem_log[$];
	logic [31:0] lfsr;
	logic mute;
	int cycle_count = 0;
	int req_rise_cycle;
	int errors;
	int tests_run;
	int tests_failed;
	// lines the tracker should be holding right now
	int pending_count;

	l2_miss_unit l2_miss_unit_inst(
		.clk(clk),
		.reset(reset),
		.req_valid(req_valid),
		.req_address(req_address),
		.req_is_miss(req_is_miss),
		.req_is_fill(req_is_fill),
		.duplicate_request(duplicate_request),
		.pending_full(pending_full),
		.mem_req(mem_req),
		.mem_address(mem_address),
		.mem_ack(mem_ack),
		.mem_error(mem_error));

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// Fibonacci feedback from taps 32, 22, 2 and 1 enters at the bottom bit
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	function automatic string test_name(input int test);
		case (test)
			1: return "first miss";
			2: return "duplicate miss";
			3: return "fill clears the line";
			4: return "memory order";
			5: return "tracker full";
			6: return "ack timeout";
			default: return "extra vectors";
		endcase
	endfunction

	task automatic report_mismatch(input string signal, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("MISMATCH %s: expected %h, got %h", signal, expected, actual);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// three LFSR steps, one per bit, give a wait of 0 to 7 cycles
	task automatic random_delay();
		int cycles;
		cycles = 0;
		for (int i = 0; i < 3; i++)
		begin
			lfsr = lfsr_next(lfsr);
			cycles = cycles * 2 + int'(lfsr[0]);
		end
		repeat (cycles)
			@(posedge clk);
	endtask

	// memory side of one four phase handshake
	task automatic serve_request();
		int waited;
		random_delay();
		@(posedge clk);
		mem_ack <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (mem_req && waited < PHASE_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		assert (!mem_req)
		else report_failure("memory: mem_req stayed high after mem_ack rose");
		random_delay();
		@(posedge clk);
		mem_ack <= 1'b0;
		@(negedge clk);
	endtask

	initial
	begin : memory_model
		logic req_seen;
		req_seen = 1'b0;
		mem_ack = 1'b0;
		forever
		begin
			@(negedge clk);
			// log each request once, muted or not
			if (mem_req && !req_seen)
			begin
				mem_log.push_back(mem_address);
				req_rise_cycle = cycle_count;
				if (!mute)
					serve_request();
			end
			req_seen = mem_req;
		end
	end

	// hold one request for a cycle, then look at the flag and the fill level
	task automatic apply_request(input string kind, input l2_line_addr_t addr, input logic dup);
		@(posedge clk);
		req_valid <= 1'b1;
		req_address <= addr;
		req_is_miss <= (kind == "miss");
		req_is_fill <= (kind == "fill");
		@(negedge clk);
		assert (duplicate_request === dup)
		else report_mismatch("duplicate_request", 32'(dup), 32'(duplicate_request));
		// a first miss takes a tracker slot and a fill gives one back
		if (kind == "miss" && !dup)
			pending_count++;
		else if (kind == "fill")
			pending_count--;
		@(posedge clk);
		req_valid <= 1'b0;
		req_is_miss <= 1'b0;
		req_is_fill <= 1'b0;
		@(negedge clk);
		assert (pending_full === (pending_count == `L2_PENDING_ENTRIES))
		else report_mismatch("pending_full", 32'(pending_count == `L2_PENDING_ENTRIES),
			32'(pending_full));
	endtask

	// memory is idle once req and ack have both stayed low for a while
	task automatic wait_until_quiet();
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < QUIET_CYCLES && waited < DRAIN_LIMIT)
		begin
			@(negedge clk);
			waited++;
			if (mem_req || mem_ack)
				quiet = 0;
			else
				quiet++;
		end
		assert (quiet >= QUIET_CYCLES) else report_failure("memory side never went idle");
	endtask

	task automatic check_ack_timeout();
		int waited;
		waited = 0;
		while (!mem_error && waited < `L2_ACK_TIMEOUT + PHASE_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		assert (mem_error === 1'b1)
		else report_failure("mem_error never rose with memory muted");
		assert (cycle_count - req_rise_cycle <= `L2_ACK_TIMEOUT + 4)
		else report_failure($sformatf("mem_error came %0d cycles after mem_req rose",
			cycle_count - req_rise_cycle));
		assert (mem_req === 1'b0) else report_mismatch("mem_req", 32'h0, 32'(mem_req));
	endtask

	task automatic check_memory_order(input int test, input int log_start);
		l2_line_addr_t expected[$];
		for (int i = 0; i < vec_test.size(); i++)
		begin
			if (vec_test[i] == test && vec_kind[i] == "mem")
				expected.push_back(vec_addr[i]);
		end
		assert (mem_log.size() - log_start == expected.size())
		else report_mismatch("memory request count", 32'(expected.size()),
			32'(mem_log.size() - log_start));
		for (int i = 0; i < expected.size(); i++)
		begin
			if (log_start + i < mem_log.size())
			begin
				assert (mem_log[log_start + i] === expected[i])
				else report_mismatch("mem_address", 32'(expected[i]),
					32'(mem_log[log_start + i]));
			end
		end
	endtask

	task automatic run_test(input int test);
		int log_start;
		int errors_before;
		logic muted_test;
		log_start = mem_log.size();
		errors_before = errors;
		muted_test = 1'b0;
		for (int i = 0; i < vec_test.size(); i++)
		begin
			if (vec_test[i] == test && vec_kind[i] == "mute")
			begin
				mute = 1'b1;
				muted_test = 1'b1;
			end
			else if (vec_test[i] == test && vec_kind[i] != "mem")
				apply_request(vec_kind[i], vec_addr[i], vec_dup[i]);
		end
		if (muted_test)
			check_ack_timeout();
		wait_until_quiet();
		check_memory_order(test, log_start);
		// the error flag is sticky, so it must follow the mute state exactly
		assert (mem_error === muted_test)
		else report_mismatch("mem_error", 32'(muted_test), 32'(mem_error));
		finish_test(test_name(test), errors_before);
	endtask

	task automatic check_reset_state();
		int errors_before;
		errors_before = errors;
		// with nothing queued mem_req has to stay low
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			assert (mem_req === 1'b0)
			else report_mismatch("mem_req", 32'h0, 32'(mem_req));
			assert (mem_error === 1'b0)
			else report_mismatch("mem_error", 32'h0, 32'(mem_error));
			assert (pending_full === 1'b0)
			else report_mismatch("pending_full", 32'h0, 32'(pending_full));
			assert (duplicate_request === 1'b0)
			else report_mismatch("duplicate_request", 32'h0, 32'(duplicate_request));
		end
		finish_test("reset values", errors_before);
	endtask

	initial
	begin : main
		int fd;
		int test_count;
		int test;
		int dup;
		string line;
		string kind;
		logic [31:0] addr;
		reset = 1'b1;
		req_valid = 1'b0;
		req_address = '0;
		req_is_miss = 1'b0;
		req_is_fill = 1'b0;
		mute = 1'b0;
		lfsr = 32'h9d50;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		pending_count = 0;
		req_rise_cycle = 0;
		test_count = 0;
		fd = $fopen("l2_miss_unit_vectors.txt", "r");
		if (fd == 0)
			report_failure("could not open l2_miss_unit_vectors.txt");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				// lines that start with a hash are comments
				if (line.len() > 0 && line.getc(0) != "#")
				begin
					if ($sscanf(line, "%d %s %h %d", test, kind, addr, dup) == 4)
					begin
						vec_test.push_back(test);
						vec_kind.push_back(kind);
						vec_addr.push_back(l2_line_addr_t'(addr));
						vec_dup.push_back(dup != 0);
						if (test > test_count)
							test_count = test;
					end
				end
			end
			$fclose(fd);
		end
		repeat (5)
			@(posedge clk);
		reset <= 1'b0;
		check_reset_state();
		for (int t = 1; t <= test_count; t++)
			run_test(t);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- l2_miss_unit_vectors.txt
# test kind addr dup: addr is a 26 bit line address in hex, dup the expected duplicate_request
# kind is miss, fill, mem (expected memory order, dup unused) or mute (memory stops acking)
1 miss 0012340 0
1 mem 0012340 0
2 miss 0012340 1
3 fill 0012340 1
3 miss 0012340 0
3 mem 0012340 0
3 fill 0012340 1
4 miss 1000001 0
4 miss 2abcdef 0
4 miss 0000000 0
4 miss 1000001 1
4 miss 3ffffff 0
4 mem 1000001 0
4 mem 2abcdef 0
4 mem 0000000 0
4 mem 3ffffff 0
5 miss 0000101 0
5 miss 0000202 0
5 miss 0000303 0
5 miss 0000404 0
5 miss 0000505 0
5 miss 0000606 0
5 miss 0000707 0
5 miss 0000808 0
5 miss 0000909 0
5 miss 0000a0a 0
5 miss 0000b0b 0
5 miss 0000c0c 0
5 fill 2abcdef 1
5 mem 0000101 0
5 mem 0000202 0
5 mem 0000303 0
5 mem 0000404 0
5 mem 0000505 0
5 mem 0000606 0
5 mem 0000707 0
5 mem 0000808 0
5 mem 0000909 0
5 mem 0000a0a 0
5 mem 0000b0b 0
5 mem 0000c0c 0
6 mute 0000000 0
6 miss 1234567 0
6 mem 1234567 0

//--- l2_miss_unit.f
+incdir+.
l2_miss_unit_pkg.sv
cam.sv
pending_miss_tracker.sv
miss_fifo.sv
mem_req_fsm.sv
ack_timer.sv
l2_miss_unit.sv
l2_miss_unit_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the L2 miss unit testbench with Verilator from the project root.
# The exit status is nonzero unless the simulation printed the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module l2_miss_unit_tb \
	-f l2_miss_unit.f -o l2_miss_unit_sim || exit 1
sim_output=$(./obj_dir/l2_miss_unit_sim)
echo "$sim_output"
echo "$sim_output" | grep -qx "All checks passed" && echo "PASS" || { echo "FAIL"; exit 1; }
